//--- design/intra4_macros.svh
`ifndef INTRA4_MACROS_SVH
`define INTRA4_MACROS_SVH

// ----------------------------------------------------------------------
// Block geometry
// ----------------------------------------------------------------------
`define PIX_W       8
`define BLK_N       4
`define NUM_MODES   4

// Datapath widths
`define SSE_W       24
`define SCORE_W     32
`define LAMBDA_W    16
`define COST_W      11

// ----------------------------------------------------------------------
// Fixed mode header costs, DC/TM/VE/HE
// ----------------------------------------------------------------------
`define COST_DC     40
`define COST_TM     1151
`define COST_VE     1723
`define COST_HE     1874

`endif

//--- design/intra4_pkg.sv
`include "intra4_macros.svh"

package intra4_pkg;

    // One luma sample
    typedef logic [`PIX_W-1:0] pixel_t;

    // Four samples of one row, column 0 in the low byte
    typedef pixel_t [`BLK_N-1:0] row_t;

    // ------------------------------------------------------------------
    // 4x4 block, row 0 in the least significant word
    // ------------------------------------------------------------------
    // Predictor and source mux use the row view,
    // per-pixel checks use index row*4 + column
    typedef union packed {
        row_t   [`BLK_N-1:0]          rows;
        pixel_t [`BLK_N*`BLK_N-1:0]   pix;
    } block_u;

    // Sweep order matches the encoding
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } mode_t;

    // Rate-distortion score, 256*SSE + lambda*cost
    typedef logic [`SCORE_W-1:0] score_t;

    // Sum of squared errors over one block
    typedef logic [`SSE_W-1:0] sse_t;

endpackage

//--- design/intra4_ctrl.sv
`timescale 1ns/10ps
`include "intra4_macros.svh"

module intra4_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    output intra4_pkg::mode_t cur_mode_o,
    output logic [1:0]        row_idx_o,
    output logic              acc_en_o,
    output logic              last_row_o,
    output logic              clear_o,
    output logic              done_o
);
    import intra4_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SWEEP  = 2'd1;
    localparam logic [1:0] ST_FINISH = 2'd2;

    logic [1:0] state_q;

    assign last_row_o = acc_en_o && (row_idx_o == 2'(`BLK_N - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            cur_mode_o <= MODE_DC;
            row_idx_o  <= '0;
            acc_en_o   <= 1'b0;
            clear_o    <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            clear_o <= 1'b0;
            done_o  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q    <= ST_SWEEP;
                        clear_o    <= 1'b1;
                        cur_mode_o <= MODE_DC;
                        row_idx_o  <= '0;
                    end
                end
                ST_SWEEP: begin
                    // First sweep cycle is the setup cycle
                    if (!acc_en_o) begin
                        acc_en_o <= 1'b1;
                    end else if (last_row_o) begin
                        row_idx_o <= '0;
                        if (cur_mode_o == mode_t'(`NUM_MODES - 1)) begin
                            acc_en_o   <= 1'b0;
                            cur_mode_o <= MODE_DC;
                            state_q    <= ST_FINISH;
                        end else begin
                            cur_mode_o <= mode_t'(cur_mode_o + 2'd1);
                        end
                    end else begin
                        row_idx_o <= row_idx_o + 2'd1;
                    end
                end
                ST_FINISH: begin
                    // Last score lands on this edge
                    done_o  <= 1'b1;
                    state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- design/intra4_predictor.sv
`timescale 1ns/10ps
`include "intra4_macros.svh"

module intra4_predictor (
    input  intra4_pkg::mode_t          mode_i,
    input  logic [1:0]                 row_idx_i,
    input  intra4_pkg::pixel_t         top_left_i,
    input  logic [2*`BLK_N*`PIX_W-1:0] top_i,
    input  intra4_pkg::row_t           left_i,
    output intra4_pkg::row_t           row_o
);
    import intra4_pkg::*;

    function automatic pixel_t avg3(input pixel_t a, input pixel_t b, input pixel_t c);
        logic [`PIX_W+1:0] s;
        s = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + (`PIX_W+2)'(2);
        return s[`PIX_W+1:2];
    endfunction

    // Neighbours with one extra sample on each side
    pixel_t                   top_ext  [0:`BLK_N+1];
    pixel_t                   left_ext [0:`BLK_N+1];
    logic [`PIX_W+2:0]        dc_sum;
    pixel_t                   dc_val;
    pixel_t                   he_val;
    logic [2:0]               row_ext;
    logic signed [`PIX_W+2:0] tm_val;

    // ------------------------------------------------------------------
    // Edge extension, DC and HE values
    // ------------------------------------------------------------------
    always_comb begin
        top_ext[0]  = top_left_i;
        left_ext[0] = top_left_i;
        for (int i = 0; i < `BLK_N; i++) begin
            top_ext[i+1]  = top_i[i*`PIX_W +: `PIX_W];
            left_ext[i+1] = left_i[i];
        end
        // First top-right pixel, left edge repeats its last sample
        top_ext[`BLK_N+1]  = top_i[`BLK_N*`PIX_W +: `PIX_W];
        left_ext[`BLK_N+1] = left_i[`BLK_N-1];

        dc_sum = (`PIX_W+3)'(4);
        for (int i = 1; i <= `BLK_N; i++) begin
            dc_sum = dc_sum + {3'b000, top_ext[i]} + {3'b000, left_ext[i]};
        end
        dc_val = dc_sum[`PIX_W+2:3];

        row_ext = {1'b0, row_idx_i};
        he_val  = avg3(left_ext[row_ext], left_ext[row_ext+3'd1], left_ext[row_ext+3'd2]);
    end

    // ------------------------------------------------------------------
    // Row output for the selected mode
    // ------------------------------------------------------------------
    always_comb begin
        for (int x = 0; x < `BLK_N; x++) begin
            tm_val = signed'({3'b000, top_ext[x+1]})
                   + signed'({3'b000, left_ext[row_ext+3'd1]})
                   - signed'({3'b000, top_left_i});
            case (mode_i)
                MODE_DC: row_o[x] = dc_val;
                MODE_TM: begin
                    // Saturate to the pixel range
                    if (tm_val < 0)
                        row_o[x] = '0;
                    else if (tm_val > (`PIX_W+3)'(255))
                        row_o[x] = '1;
                    else
                        row_o[x] = tm_val[`PIX_W-1:0];
                end
                MODE_VE: row_o[x] = avg3(top_ext[x], top_ext[x+1], top_ext[x+2]);
                MODE_HE: row_o[x] = he_val;
            endcase
        end
    end

endmodule

//--- design/sse_accum.sv
`timescale 1ns/10ps
`include "intra4_macros.svh"

module sse_accum (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               acc_en_i,
    input  logic               last_row_i,
    input  logic [1:0]         row_idx_i,
    input  intra4_pkg::row_t   src_row_i,
    input  intra4_pkg::row_t   pred_row_i,
    output intra4_pkg::sse_t   sse_o,
    output logic               sse_valid_o,
    output intra4_pkg::block_u mode_pred_o
);
    import intra4_pkg::*;

    sse_t                acc_q;
    logic [2*`PIX_W+1:0] row_sse;
    logic [`PIX_W-1:0]   abs_diff;
    logic [2*`PIX_W-1:0] sq;
    block_u              blk_q;
    block_u              blk_next;

    // Squared error of the current row
    always_comb begin
        row_sse = '0;
        for (int x = 0; x < `BLK_N; x++) begin
            if (src_row_i[x] > pred_row_i[x])
                abs_diff = src_row_i[x] - pred_row_i[x];
            else
                abs_diff = pred_row_i[x] - src_row_i[x];
            sq      = abs_diff * abs_diff;
            row_sse = row_sse + {2'b00, sq};
        end
    end

    always_comb begin
        blk_next                 = blk_q;
        blk_next.rows[row_idx_i] = pred_row_i;
    end

    always_ff @(posedge clk) begin
        if (acc_en_i)
            blk_q <= blk_next;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q       <= '0;
            sse_o       <= '0;
            sse_valid_o <= 1'b0;
            mode_pred_o <= '0;
        end else begin
            sse_valid_o <= acc_en_i && last_row_i;
            if (acc_en_i) begin
                if (last_row_i) begin
                    // Hand off this mode and restart for the next one
                    sse_o       <= acc_q + sse_t'(row_sse);
                    mode_pred_o <= blk_next;
                    acc_q       <= '0;
                end else begin
                    acc_q <= acc_q + sse_t'(row_sse);
                end
            end
        end
    end

endmodule

//--- design/mode_select.sv
`timescale 1ns/10ps
`include "intra4_macros.svh"

module mode_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear_i,
    input  logic                 sse_valid_i,
    input  intra4_pkg::sse_t     sse_i,
    input  intra4_pkg::mode_t    mode_i,
    input  intra4_pkg::block_u   mode_pred_i,
    input  logic [`LAMBDA_W-1:0] lambda_i,
    output intra4_pkg::mode_t    best_mode_o,
    output intra4_pkg::score_t   best_score_o,
    output intra4_pkg::block_u   best_pred_o
);
    import intra4_pkg::*;

    logic [`COST_W-1:0] mode_cost;
    score_t             cand_score;
    logic               first_q;

    always_comb begin
        case (mode_i)
            MODE_DC: mode_cost = `COST_W'(`COST_DC);
            MODE_TM: mode_cost = `COST_W'(`COST_TM);
            MODE_VE: mode_cost = `COST_W'(`COST_VE);
            MODE_HE: mode_cost = `COST_W'(`COST_HE);
        endcase
    end

    // 256*SSE + lambda*cost
    assign cand_score = score_t'({sse_i, 8'd0}) + score_t'(lambda_i) * score_t'(mode_cost);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_q      <= 1'b0;
            best_mode_o  <= MODE_DC;
            best_score_o <= '0;
            best_pred_o  <= '0;
        end else begin
            if (clear_i)
                first_q <= 1'b1;
            // Strict compare, so ties keep the earlier mode
            if (sse_valid_i && (first_q || cand_score < best_score_o)) begin
                first_q      <= 1'b0;
                best_mode_o  <= mode_i;
                best_score_o <= cand_score;
                best_pred_o  <= mode_pred_i;
            end
        end
    end

endmodule

//--- design/pick_best_intra4.sv
`timescale 1ns/10ps
`include "intra4_macros.svh"

module pick_best_intra4 (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    input  intra4_pkg::block_u         src_i,
    input  intra4_pkg::pixel_t         top_left_i,
    input  logic [2*`BLK_N*`PIX_W-1:0] top_i,
    input  intra4_pkg::row_t           left_i,
    input  logic [`LAMBDA_W-1:0]       lambda_i,
    output logic                       done_o,
    output intra4_pkg::mode_t          mode_o,
    output intra4_pkg::score_t         score_o,
    output intra4_pkg::block_u         pred_o
);

    intra4_pkg::mode_t  cur_mode;
    intra4_pkg::mode_t  scored_mode;
    logic [1:0]         row_idx;
    logic               acc_en;
    logic               last_row;
    logic               clear;
    intra4_pkg::row_t   src_row;
    intra4_pkg::row_t   pred_row;
    intra4_pkg::sse_t   sse;
    logic               sse_valid;
    intra4_pkg::block_u mode_pred;

    assign src_row = src_i.rows[row_idx];

    // SSE of a mode is ready one step after the counter has moved on
    assign scored_mode = intra4_pkg::mode_t'(cur_mode - 2'd1);

    intra4_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .cur_mode_o (cur_mode),
        .row_idx_o  (row_idx),
        .acc_en_o   (acc_en),
        .last_row_o (last_row),
        .clear_o    (clear),
        .done_o     (done_o)
    );

    intra4_predictor u_pred (
        .mode_i     (cur_mode),
        .row_idx_i  (row_idx),
        .top_left_i (top_left_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .row_o      (pred_row)
    );

    sse_accum u_sse (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_en_i    (acc_en),
        .last_row_i  (last_row),
        .row_idx_i   (row_idx),
        .src_row_i   (src_row),
        .pred_row_i  (pred_row),
        .sse_o       (sse),
        .sse_valid_o (sse_valid),
        .mode_pred_o (mode_pred)
    );

    mode_select u_sel (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear_i      (clear),
        .sse_valid_i  (sse_valid),
        .sse_i        (sse),
        .mode_i       (scored_mode),
        .mode_pred_i  (mode_pred),
        .lambda_i     (lambda_i),
        .best_mode_o  (mode_o),
        .best_score_o (score_o),
        .best_pred_o  (pred_o)
    );

endmodule

//--- test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'h78d3_ae09;

// One LFSR step per bit, first bit taken ends up as the MSB
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = {val[30:0], lfsr_state[0]};
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        else
            lfsr_state = lfsr_state >> 1;
    end
    return val;
endfunction

function automatic int avg3_ref(input int a, input int b, input int c);
    return (a + 2 * b + c + 2) / 4;
endfunction

function automatic int cost_of(input mode_t m);
    int c;
    case (m)
        MODE_DC: c = `COST_DC;
        MODE_TM: c = `COST_TM;
        MODE_VE: c = `COST_VE;
        default: c = `COST_HE;
    endcase
    return c;
endfunction

// ----------------------------------------------------------------------
// Whole-block prediction for one mode
// ----------------------------------------------------------------------
function automatic block_u predict_block(input mode_t m, input pixel_t tl,
                                         input logic [63:0] top, input row_t left);
    block_u blk;
    int     t [0:5];
    int     l [0:5];
    int     dc;
    int     v;
    // Index 0 is the corner, 5 the extension past the edge
    t[0] = int'(tl);
    l[0] = int'(tl);
    for (int i = 0; i < 4; i++) begin
        t[i+1] = int'(top[8*i +: 8]);
        l[i+1] = int'(left[i]);
    end
    t[5] = int'(top[39:32]);
    l[5] = int'(left[3]);
    dc = 4;
    for (int i = 1; i <= 4; i++) begin
        dc = dc + t[i] + l[i];
    end
    dc = dc / 8;
    for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
            case (m)
                MODE_DC: v = dc;
                MODE_TM: begin
                    v = t[x+1] + l[y+1] - t[0];
                    if (v < 0)
                        v = 0;
                    else if (v > 255)
                        v = 255;
                end
                MODE_VE: v = avg3_ref(t[x], t[x+1], t[x+2]);
                default: v = avg3_ref(l[y], l[y+1], l[y+2]);
            endcase
            blk.pix[4*y + x] = pixel_t'(v);
        end
    end
    return blk;
endfunction

function automatic int block_sse(input block_u a, input block_u b);
    int sum;
    int d;
    sum = 0;
    for (int i = 0; i < 16; i++) begin
        d   = int'(a.pix[i]) - int'(b.pix[i]);
        sum = sum + d * d;
    end
    return sum;
endfunction

// Lowest 256*SSE + lambda*cost, ties keep the lower mode
function automatic void ref_best(input block_u src, input pixel_t tl,
                                 input logic [63:0] top, input row_t left,
                                 input logic [15:0] lambda, output mode_t best_m,
                                 output score_t best_s, output block_u best_p);
    block_u p;
    longint s;
    longint best;
    best   = -1;
    best_m = MODE_DC;
    best_p = '0;
    for (int m = 0; m < `NUM_MODES; m++) begin
        p = predict_block(mode_t'(m), tl, top, left);
        s = (longint'(block_sse(src, p)) << 8)
          + longint'(lambda) * longint'(cost_of(mode_t'(m)));
        if (best < 0 || s < best) begin
            best   = s;
            best_m = mode_t'(m);
            best_p = p;
        end
    end
    best_s = score_t'(best);
endfunction

`endif

//--- test/tb_pick_best_intra4.sv
`timescale 1ns/10ps
`include "intra4_macros.svh"

module tb_pick_best_intra4;
    import intra4_pkg::*;

    localparam int NUM_TESTS    = 47;
    localparam int TEST_CYCLES  = 30;
    localparam int RESET_CYCLES = 2;
    localparam int MAX_WAIT     = 60;
    // Setup cycle, one cycle per row per mode, result cycle
    localparam int LATENCY      = 2 + `NUM_MODES * `BLK_N;

    logic                       clk;
    logic                       rst_n;
    logic                       start_i;
    block_u                     src_i;
    pixel_t                     top_left_i;
    logic [2*`BLK_N*`PIX_W-1:0] top_i;
    row_t                       left_i;
    logic [`LAMBDA_W-1:0]       lambda_i;
    logic                       done_o;
    mode_t                      mode_o;
    score_t                     score_o;
    block_u                     pred_o;

    int tests_run;
    int checks;
    int errors;

    // Expected results, one entry per started test
    string  name_q      [$];
    mode_t  exp_mode_q  [$];
    score_t exp_score_q [$];
    block_u exp_pred_q  [$];

    `include "tb_ref_model.svh"

    pick_best_intra4 dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .src_i      (src_i),
        .top_left_i (top_left_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .lambda_i   (lambda_i),
        .done_o     (done_o),
        .mode_o     (mode_o),
        .score_o    (score_o),
        .pred_o     (pred_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_mode(input string name, input mode_t got, input mode_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED mode_o in %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED score_o in %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pred(input string name, input block_u got, input block_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED pred_o in %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED done_o latency in %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic random_inputs(output block_u src, output logic [63:0] top,
                                 output row_t left, output pixel_t tl,
                                 output logic [`LAMBDA_W-1:0] lambda);
        for (int r = 0; r < `BLK_N; r++) begin
            src.rows[r] = rand_bits(32);
        end
        top[31:0]  = rand_bits(32);
        top[63:32] = rand_bits(32);
        left       = rand_bits(32);
        tl         = pixel_t'(rand_bits(8));
        lambda     = `LAMBDA_W'(rand_bits(12));
    endtask

    // Idle cycles with changing inputs, results must not move
    task automatic hold_outputs(input string name, input int n, input mode_t m,
                                input score_t s, input block_u p);
        repeat (n) begin
            @(posedge clk);
            #2;
            if (done_o) begin
                errors++;
                $display("%s: done_o pulsed although no start was accepted", name);
            end
            check_mode(name, mode_o, m);
            check_score(name, score_o, s);
            check_pred(name, pred_o, p);
            random_inputs(src_i, top_i, left_i, top_left_i, lambda_i);
        end
    endtask

    task automatic run_test(input string name, input block_u src, input pixel_t tl,
                            input logic [63:0] top, input row_t left,
                            input logic [`LAMBDA_W-1:0] lambda, input int pulse_at,
                            input int hold_cycles);
        mode_t  m;
        score_t s;
        block_u p;
        int     cycles;
        int     err_start;

        ref_best(src, tl, top, left, lambda, m, s, p);
        name_q.push_back(name);
        exp_mode_q.push_back(m);
        exp_score_q.push_back(s);
        exp_pred_q.push_back(p);
        err_start = errors;
        @(posedge clk);
        #2;
        src_i      = src;
        top_left_i = tl;
        top_i      = top;
        left_i     = left;
        lambda_i   = lambda;
        start_i    = 1'b1;
        cycles     = -1;
        while (!done_o && cycles < MAX_WAIT) begin
            @(posedge clk);
            #2;
            cycles++;
            // Optional extra pulse while the sweep is running
            start_i = (cycles == pulse_at);
        end
        if (done_o) begin
            check_cycles(name, cycles, LATENCY);
        end else begin
            errors++;
            $display("%s: done_o did not rise within %0d cycles of start_i", name, MAX_WAIT);
        end
        // Compare process samples done_o on the falling edge
        @(posedge clk);
        #1;
        if (hold_cycles > 0)
            hold_outputs(name, hold_cycles, m, s, p);
        tests_run++;
        $display("test %2d %-14s %s", tests_run, name, (errors == err_start) ? "ok" : "FAILED");
    endtask

    initial begin : compare_results
        string  name;
        mode_t  m;
        score_t s;
        block_u p;

        forever begin
            @(negedge clk);
            if (done_o) begin
                if (name_q.size() == 0) begin
                    errors++;
                    $display("done_o pulsed with no test waiting for a result");
                end else begin
                    name = name_q.pop_front();
                    m    = exp_mode_q.pop_front();
                    s    = exp_score_q.pop_front();
                    p    = exp_pred_q.pop_front();
                    check_mode(name, mode_o, m);
                    check_score(name, score_o, s);
                    check_pred(name, pred_o, p);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin : stimulus
        block_u                     src;
        logic [2*`BLK_N*`PIX_W-1:0] top;
        row_t                       left;
        pixel_t                     tl;
        logic [`LAMBDA_W-1:0]       lambda;

        rst_n      = 1'b0;
        start_i    = 1'b0;
        src_i      = '0;
        top_left_i = '0;
        top_i      = '0;
        left_i     = '0;
        lambda_i   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;

        // Flat block, every mode predicts it exactly
        src = {16{8'd100}};
        run_test("flat", src, 8'd100, {8{8'd100}}, {4{8'd100}}, 16'd37, -1, 0);
        // All four modes tie at score 0 so DC must win
        run_test("flat_tie", src, 8'd100, {8{8'd100}}, {4{8'd100}}, 16'd0, -1, 0);

        // Columns follow the top row, left edge far off
        top  = {8'd0, 8'd0, 8'd0, 8'd170, 8'd140, 8'd110, 8'd80, 8'd50};
        left = {4{8'd250}};
        for (int y = 0; y < `BLK_N; y++) begin
            src.rows[y] = top[31:0];
        end
        run_test("gradient_l0", src, 8'd20, top, left, 16'd0, -1, 0);
        run_test("gradient_lmax", src, 8'd20, top, left, 16'hffff, -1, 0);

        for (int n = 0; n < 40; n++) begin
            random_inputs(src, top, left, tl, lambda);
            run_test($sformatf("random_%0d", n), src, tl, top, left, lambda, -1, 0);
        end

        // Second start mid-sweep, then idle cycles
        random_inputs(src, top, left, tl, lambda);
        run_test("restart", src, tl, top, left, lambda, 6, 10);

        // TM saturation at both ends, source equal to the TM prediction
        tl   = 8'd128;
        top  = {32'h0, 8'd255, 8'd255, 8'd0, 8'd0};
        left = {8'd255, 8'd0, 8'd255, 8'd0};
        src  = predict_block(MODE_TM, tl, top, left);
        run_test("tm_clip_a", src, tl, top, left, 16'd0, -1, 0);
        tl   = 8'd200;
        top  = {32'h0, 8'd240, 8'd30, 8'd250, 8'd10};
        left = {8'd245, 8'd20, 8'd250, 8'd5};
        src  = predict_block(MODE_TM, tl, top, left);
        run_test("tm_clip_b", src, tl, top, left, 16'd0, -1, 0);

        @(posedge clk);
        if (name_q.size() != 0) begin
            errors++;
            $display("%0d results were never returned by the DUT", name_q.size());
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin : watchdog
        #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * 20);
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * TEST_CYCLES + RESET_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- list.f
+incdir+design
+incdir+test
design/intra4_pkg.sv
design/intra4_ctrl.sv
design/intra4_predictor.sv
design/sse_accum.sv
design/mode_select.sv
design/pick_best_intra4.sv
test/tb_pick_best_intra4.sv

//--- Makefile
# Verilator simulation of the 4x4 intra mode picker

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f list.f --top-module tb_pick_best_intra4 -Mdir obj_dir
	./obj_dir/Vtb_pick_best_intra4 | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
